// File: source/portal_settings.svh
`ifndef PORTAL_SETTINGS_SVH
`define PORTAL_SETTINGS_SVH

// AXI side widths
`define ADDR_W 13
`define DATA_W 32
`define ID_W 6
`define LEN_W 4

`define OFFSET_W 5          // Byte offset within a 32-byte page
`define BEAT_QUEUE_DEPTH 2
`define ECHO_DEPTH 8

// Fixed control page values
`define NUM_TILES 1
`define PORTAL_ID 5
`define NUM_PORTALS 1
`define UNMAPPED_PATTERN 32'h005A05A0

`endif

// File: source/axiPkg.sv
`default_nettype none
`include "portal_settings.svh"

package axiPkg;

  typedef logic [`ADDR_W-1:0] axiAddrT;

  typedef logic [`DATA_W-1:0] axiDataT;

  typedef logic [`ID_W-1:0] axiIdT;

  // Beats minus one
  typedef logic [`LEN_W-1:0] axiLenT;

  typedef logic [1:0] axiRespT;  // 0 is OKAY

endpackage

`default_nettype wire

// File: source/portalPkg.sv
`default_nettype none
`include "portal_settings.svh"

package portalPkg;

  typedef logic [`OFFSET_W-1:0] offsetT;

  typedef enum logic {
    ctrlPage,
    userPage
  } pageT;

  // One word beat of a split burst
  typedef struct packed {
    offsetT offset;
    axiPkg::axiIdT id;
    logic last;
    pageT page;
  } beatT;

  typedef enum logic [`OFFSET_W-1:0] {
    intStatus   = 5'h00,
    intEnable   = 5'h04,
    numTiles    = 5'h08,
    queueStatus = 5'h0C,
    portalId    = 5'h10,
    numPortals  = 5'h14
  } ctrlRegT;

  typedef logic [$clog2(`ECHO_DEPTH):0] countT;  // Occupancy 0 to ECHO_DEPTH

endpackage

`default_nettype wire

// File: source/beatIf.sv
`timescale 1ns/1ps
`default_nettype none

interface beatIf;

  logic valid;
  logic ready;
  portalPkg::beatT beat;

  modport source (
    output valid,
    output beat,
    input  ready
  );

  modport sink (
    input  valid,
    input  beat,
    output ready
  );

endinterface

`default_nettype wire

// File: source/beatQueue.sv
`timescale 1ns/1ps
`default_nettype none
`include "portal_settings.svh"

module beatQueue #(
  parameter type payloadT = logic,
  parameter int DEPTH = `BEAT_QUEUE_DEPTH
) (
  input  logic    CLK,
  input  logic    RST_N,
  input  logic    push,
  input  payloadT pushData,
  output logic    notFull,
  input  logic    pop,
  output payloadT popData,
  output logic    notEmpty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = PTR_W + 1;

  payloadT mem [DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] count;

  assign notFull = count != CNT_W'(DEPTH);
  assign notEmpty = count != '0;
  assign popData = mem[rdPtr];

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push)
        wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      if (pop)
        rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge CLK) begin
    if (push)
      mem[wrPtr] <= pushData;
  end

  // Callers must honour the flags
  noOverflow: assert property (@(posedge CLK) disable iff (!RST_N) push |-> notFull);
  noUnderflow: assert property (@(posedge CLK) disable iff (!RST_N) pop |-> notEmpty);

endmodule

`default_nettype wire

// File: source/burstSplitter.sv
`timescale 1ns/1ps
`default_nettype none
`include "portal_settings.svh"

module burstSplitter (
  input  logic            CLK,
  input  logic            RST_N,
  input  logic            addrValid,
  output logic            addrReady,
  input  axiPkg::axiAddrT addr,
  input  axiPkg::axiIdT   id,
  input  axiPkg::axiLenT  len,
  beatIf.source           beats
);

  typedef struct packed {
    axiPkg::axiAddrT addr;
    axiPkg::axiIdT id;
    axiPkg::axiLenT len;
  } addrEntryT;

  addrEntryT head;
  logic headValid;
  logic load;
  logic fire;
  logic active;
  portalPkg::offsetT offset;
  portalPkg::pageT curPage;
  axiPkg::axiIdT curId;
  axiPkg::axiLenT remaining;
  axiPkg::axiLenT curLen;
  axiPkg::axiLenT sentCount;

  beatQueue #(.payloadT(addrEntryT)) addrQueue (
    .CLK(CLK),
    .RST_N(RST_N),
    .push(addrValid && addrReady),
    .pushData({addr, id, len}),
    .notFull(addrReady),
    .pop(load),
    .popData(head),
    .notEmpty(headValid)
  );

  assign fire = beats.valid && beats.ready;
  // Next burst starts right behind the last beat
  assign load = headValid && (!active || (fire && beats.beat.last));

  assign beats.valid = active;
  assign beats.beat = '{offset: offset, id: curId, last: remaining == '0, page: curPage};

  always_ff @(posedge CLK) begin
    if (!RST_N)
      active <= 1'b0;
    else if (load)
      active <= 1'b1;
    else if (fire && beats.beat.last)
      active <= 1'b0;
  end

  always_ff @(posedge CLK) begin
    if (load) begin
      offset <= head.addr[`OFFSET_W-1:0];
      curId <= head.id;
      // Top address bit is not decoded
      curPage <= (head.addr[`ADDR_W-2:`OFFSET_W] == '0) ? portalPkg::ctrlPage
                                                         : portalPkg::userPage;
      remaining <= head.len;
      curLen <= head.len;
      sentCount <= '0;
    end else if (fire) begin
      offset <= offset + portalPkg::offsetT'(4);  // Wraps inside the page
      remaining <= remaining - 1'b1;
      sentCount <= sentCount + 1'b1;
    end
  end

  lastOnFinalBeat: assert property (@(posedge CLK) disable iff (!RST_N)
    fire |-> (beats.beat.last == (sentCount == curLen)));

endmodule

`default_nettype wire

// File: source/portalReadPath.sv
`timescale 1ns/1ps
`default_nettype none
`include "portal_settings.svh"

module portalReadPath (
  input  logic              CLK,
  input  logic              RST_N,
  beatIf.sink               beats,
  input  logic              intEnable,
  input  portalPkg::countT  pending,
  input  logic              reqNotFull,
  input  logic              indValid,
  input  axiPkg::axiDataT   indData,
  output logic              indPop,
  output logic              rValid,
  input  logic              rReady,
  output axiPkg::axiDataT   rData,
  output axiPkg::axiIdT     rId,
  output logic              rLast,
  output axiPkg::axiRespT   rResp
);

  typedef struct packed {
    axiPkg::axiDataT data;
    axiPkg::axiIdT id;
    logic last;
  } rBeatT;

  rBeatT rHead;
  axiPkg::axiDataT ctrlValue;
  axiPkg::axiDataT userValue;
  logic isCtrl;
  logic needInd;
  logic rqNotFull;
  logic accept;

  assign isCtrl = beats.beat.page == portalPkg::ctrlPage;
  assign needInd = !isCtrl && (beats.beat.offset < portalPkg::offsetT'(5'h10));

  // Hold the beat until an indication word is there
  assign beats.ready = rqNotFull && (!needInd || indValid);
  assign accept = beats.valid && beats.ready;
  assign indPop = accept && needInd;

  always_comb begin
    case (portalPkg::ctrlRegT'(beats.beat.offset))
      portalPkg::intStatus:   ctrlValue = axiPkg::axiDataT'(pending != '0);
      portalPkg::intEnable:   ctrlValue = axiPkg::axiDataT'(intEnable);
      portalPkg::numTiles:    ctrlValue = axiPkg::axiDataT'(`NUM_TILES);
      portalPkg::queueStatus: ctrlValue = axiPkg::axiDataT'(pending);
      portalPkg::portalId:    ctrlValue = axiPkg::axiDataT'(`PORTAL_ID);
      portalPkg::numPortals:  ctrlValue = axiPkg::axiDataT'(`NUM_PORTALS);
      default:                ctrlValue = `UNMAPPED_PATTERN;
    endcase
  end

  assign userValue = needInd ? indData : axiPkg::axiDataT'(reqNotFull);

  beatQueue #(.payloadT(rBeatT)) rQueue (
    .CLK(CLK),
    .RST_N(RST_N),
    .push(accept),
    .pushData({isCtrl ? ctrlValue : userValue, beats.beat.id, beats.beat.last}),
    .notFull(rqNotFull),
    .pop(rValid && rReady),
    .popData(rHead),
    .notEmpty(rValid)
  );

  assign rData = rHead.data;
  assign rId = rHead.id;
  assign rLast = rHead.last;
  assign rResp = '0;  // OKAY

  popOnlyWhenPending: assert property (@(posedge CLK) disable iff (!RST_N)
    indPop |-> pending != '0);

endmodule

`default_nettype wire

// File: source/portalWritePath.sv
`timescale 1ns/1ps
`default_nettype none

module portalWritePath (
  input  logic            CLK,
  input  logic            RST_N,
  beatIf.sink             beats,
  input  logic            wValid,
  output logic            wReady,
  input  axiPkg::axiDataT wData,
  output logic            reqPush,
  output axiPkg::axiDataT reqData,
  input  logic            reqNotFull,
  output logic            intEnable,
  output logic            bValid,
  input  logic            bReady,
  output axiPkg::axiIdT   bId,
  output axiPkg::axiRespT bResp
);

  axiPkg::axiDataT wHead;
  logic wqNotEmpty;
  logic bqNotFull;
  logic isUser;
  logic accept;

  assign isUser = beats.beat.page == portalPkg::userPage;

  // Needs a data word, request space and room for B on the last beat
  assign beats.ready = wqNotEmpty
                    && (!isUser || reqNotFull)
                    && (!beats.beat.last || bqNotFull);
  assign accept = beats.valid && beats.ready;

  assign reqPush = accept && isUser;
  assign reqData = wHead;
  assign bResp = '0;  // OKAY

  beatQueue #(.payloadT(axiPkg::axiDataT)) wQueue (
    .CLK(CLK),
    .RST_N(RST_N),
    .push(wValid && wReady),
    .pushData(wData),
    .notFull(wReady),
    .pop(accept),
    .popData(wHead),
    .notEmpty(wqNotEmpty)
  );

  beatQueue #(.payloadT(axiPkg::axiIdT)) bQueue (
    .CLK(CLK),
    .RST_N(RST_N),
    .push(accept && beats.beat.last),
    .pushData(beats.beat.id),
    .notFull(bqNotFull),
    .pop(bValid && bReady),
    .popData(bId),
    .notEmpty(bValid)
  );

  always_ff @(posedge CLK) begin
    if (!RST_N)
      intEnable <= 1'b0;
    else if (accept && !isUser && beats.beat.offset == portalPkg::intEnable)
      intEnable <= wHead[0];
  end

endmodule

`default_nettype wire

// File: source/echoPortal.sv
`timescale 1ns/1ps
`default_nettype none
`include "portal_settings.svh"

module echoPortal (
  input  logic             CLK,
  input  logic             RST_N,
  input  logic             reqPush,
  input  axiPkg::axiDataT  reqData,
  output logic             reqNotFull,
  input  logic             indPop,
  output logic             indValid,
  output axiPkg::axiDataT  indData,
  output portalPkg::countT pending
);

  localparam int PTR_W = $clog2(`ECHO_DEPTH);

  axiPkg::axiDataT mem [`ECHO_DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  portalPkg::countT count;

  assign reqNotFull = count != portalPkg::countT'(`ECHO_DEPTH);
  assign indValid = count != '0;
  assign indData = mem[rdPtr];  // Request word comes back unchanged
  assign pending = count;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (reqPush)
        wrPtr <= (wrPtr == PTR_W'(`ECHO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      if (indPop)
        rdPtr <= (rdPtr == PTR_W'(`ECHO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      count <= count + portalPkg::countT'(reqPush) - portalPkg::countT'(indPop);
    end
  end

  always_ff @(posedge CLK) begin
    if (reqPush)
      mem[wrPtr] <= reqData;
  end

  countInRange: assert property (@(posedge CLK) disable iff (!RST_N)
    count <= portalPkg::countT'(`ECHO_DEPTH));

endmodule

`default_nettype wire

// File: source/zynqPortalTop.sv
`timescale 1ns/1ps
`default_nettype none

module zynqPortalTop (
  input  logic            CLK,
  input  logic            RST_N,
  input  logic            awValid,
  output logic            awReady,
  input  axiPkg::axiAddrT awAddr,
  input  axiPkg::axiIdT   awId,
  input  axiPkg::axiLenT  awLen,
  input  logic            wValid,
  output logic            wReady,
  input  axiPkg::axiDataT wData,
  input  logic            wLast,
  output logic            bValid,
  input  logic            bReady,
  output axiPkg::axiIdT   bId,
  output axiPkg::axiRespT bResp,
  input  logic            arValid,
  output logic            arReady,
  input  axiPkg::axiAddrT arAddr,
  input  axiPkg::axiIdT   arId,
  input  axiPkg::axiLenT  arLen,
  output logic            rValid,
  input  logic            rReady,
  output axiPkg::axiDataT rData,
  output axiPkg::axiIdT   rId,
  output logic            rLast,
  output axiPkg::axiRespT rResp,
  output logic            irq
);

  beatIf rdBeats ();
  beatIf wrBeats ();

  portalPkg::countT pending;
  axiPkg::axiDataT reqData;
  axiPkg::axiDataT indData;
  logic intEnable;
  logic reqPush;
  logic reqNotFull;
  logic indPop;
  logic indValid;
  logic [3:0] wBursts;  // W bursts closed by wLast and not yet answered

  burstSplitter arSplit (
    .CLK(CLK),
    .RST_N(RST_N),
    .addrValid(arValid),
    .addrReady(arReady),
    .addr(arAddr),
    .id(arId),
    .len(arLen),
    .beats(rdBeats)
  );

  burstSplitter awSplit (
    .CLK(CLK),
    .RST_N(RST_N),
    .addrValid(awValid),
    .addrReady(awReady),
    .addr(awAddr),
    .id(awId),
    .len(awLen),
    .beats(wrBeats)
  );

  portalReadPath readPath (
    .CLK(CLK),
    .RST_N(RST_N),
    .beats(rdBeats),
    .intEnable(intEnable),
    .pending(pending),
    .reqNotFull(reqNotFull),
    .indValid(indValid),
    .indData(indData),
    .indPop(indPop),
    .rValid(rValid),
    .rReady(rReady),
    .rData(rData),
    .rId(rId),
    .rLast(rLast),
    .rResp(rResp)
  );

  portalWritePath writePath (
    .CLK(CLK),
    .RST_N(RST_N),
    .beats(wrBeats),
    .wValid(wValid),
    .wReady(wReady),
    .wData(wData),
    .reqPush(reqPush),
    .reqData(reqData),
    .reqNotFull(reqNotFull),
    .intEnable(intEnable),
    .bValid(bValid),
    .bReady(bReady),
    .bId(bId),
    .bResp(bResp)
  );

  echoPortal echo (
    .CLK(CLK),
    .RST_N(RST_N),
    .reqPush(reqPush),
    .reqData(reqData),
    .reqNotFull(reqNotFull),
    .indPop(indPop),
    .indValid(indValid),
    .indData(indData),
    .pending(pending)
  );

  assign irq = (pending != '0) && intEnable;

  always_ff @(posedge CLK) begin
    if (!RST_N)
      wBursts <= '0;
    else
      wBursts <= wBursts + 4'(wValid && wReady && wLast) - 4'(bValid && bReady);
  end

  // Host framing on W has to agree with AW length
  bAfterWLast: assert property (@(posedge CLK) disable iff (!RST_N)
    (bValid && bReady) |-> (wBursts != '0));

endmodule

`default_nettype wire

// File: tests/portalTb.sv
`timescale 1ns/1ps
`default_nettype none

module portalTb;

  localparam int MAX_TESTS = 64;
  localparam int MAX_WORDS = 8;
  localparam int CYCLES_PER_TEST = 200;

  logic CLK;
  logic RST_N;
  logic awValid;
  logic awReady;
  axiPkg::axiAddrT awAddr;
  axiPkg::axiIdT awId;
  axiPkg::axiLenT awLen;
  logic wValid;
  logic wReady;
  axiPkg::axiDataT wData;
  logic wLast;
  logic bValid;
  logic bReady;
  axiPkg::axiIdT bId;
  axiPkg::axiRespT bResp;
  logic arValid;
  logic arReady;
  axiPkg::axiAddrT arAddr;
  axiPkg::axiIdT arId;
  axiPkg::axiLenT arLen;
  logic rValid;
  logic rReady;
  axiPkg::axiDataT rData;
  axiPkg::axiIdT rId;
  logic rLast;
  axiPkg::axiRespT rResp;
  logic irq;

  // One entry per stimulus line
  string testName [MAX_TESTS];
  string testOp [MAX_TESTS];
  axiPkg::axiAddrT testAddr [MAX_TESTS];
  axiPkg::axiLenT testLen [MAX_TESTS];
  axiPkg::axiIdT testId [MAX_TESTS];
  axiPkg::axiDataT testWords [MAX_TESTS][MAX_WORDS];
  int numTests;
  logic loaded;
  logic [7:0] lfsr;

  zynqPortalTop DUT (
    .CLK(CLK),
    .RST_N(RST_N),
    .awValid(awValid),
    .awReady(awReady),
    .awAddr(awAddr),
    .awId(awId),
    .awLen(awLen),
    .wValid(wValid),
    .wReady(wReady),
    .wData(wData),
    .wLast(wLast),
    .bValid(bValid),
    .bReady(bReady),
    .bId(bId),
    .bResp(bResp),
    .arValid(arValid),
    .arReady(arReady),
    .arAddr(arAddr),
    .arId(arId),
    .arLen(arLen),
    .rValid(rValid),
    .rReady(rReady),
    .rData(rData),
    .rId(rId),
    .rLast(rLast),
    .rResp(rResp),
    .irq(irq)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsrStep(input logic [7:0] state);
    lfsrStep = {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
  endfunction

  task automatic stopRun();
    $display("*** TEST FAILED ***");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic checkData(input string name, input axiPkg::axiDataT expected,
                           input axiPkg::axiDataT actual);
    if (actual !== expected) begin
      $display("FAIL %s data: expected %h, actual %h", name, expected, actual);
      stopRun();
    end
  endtask

  task automatic checkId(input string name, input axiPkg::axiIdT expected,
                         input axiPkg::axiIdT actual);
    if (actual !== expected) begin
      $display("FAIL %s id: expected %h, actual %h", name, expected, actual);
      stopRun();
    end
  endtask

  task automatic checkResp(input string name, input axiPkg::axiRespT expected,
                           input axiPkg::axiRespT actual);
    if (actual !== expected) begin
      $display("FAIL %s resp: expected %h, actual %h", name, expected, actual);
      stopRun();
    end
  endtask

  task automatic checkLast(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAIL %s rLast: expected %b, actual %b", name, expected, actual);
      stopRun();
    end
  endtask

  task automatic checkIrq(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAIL %s irq: expected %b, actual %b", name, expected, actual);
      stopRun();
    end
  endtask

  task automatic loadStim();
    int fd;
    int n;
    int wanted;
    string line;
    string nm;
    string op;
    logic [31:0] a;
    logic [31:0] l;
    logic [31:0] d;
    logic [31:0] w [MAX_WORDS];
    numTests = 0;
    fd = $fopen("tests/portalStim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file tests/portalStim.txt");
      stopRun();
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) != 0) begin
          n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h %h", nm, op, a, l, d,
                      w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7]);
          if (n >= 5 && nm.substr(0, 0) != "#") begin
            wanted = (op == "I") ? 6 : 6 + int'(l);
            if ((op != "W" && op != "R" && op != "I") || n != wanted
                || numTests == MAX_TESTS) begin
              $display("Stimulus line for %s is malformed or the file has too many lines", nm);
              stopRun();
            end else begin
              testName[numTests] = nm;
              testOp[numTests] = op;
              testAddr[numTests] = a[12:0];
              testLen[numTests] = l[3:0];
              testId[numTests] = d[5:0];
              for (int i = 0; i < MAX_WORDS; i++)
                testWords[numTests][i] = w[i];
              numTests++;
            end
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic writeBurst(input int t);
    @(posedge CLK);
    awValid <= 1'b1;
    awAddr <= testAddr[t];
    awId <= testId[t];
    awLen <= testLen[t];
    @(negedge CLK);
    while (!awReady) @(negedge CLK);
    for (int i = 0; i <= int'(testLen[t]); i++) begin
      @(posedge CLK);
      awValid <= 1'b0;
      wValid <= 1'b1;
      wData <= testWords[t][i];
      wLast <= (i == int'(testLen[t]));
      @(negedge CLK);
      while (!wReady) @(negedge CLK);
    end
    @(posedge CLK);
    wValid <= 1'b0;
    wLast <= 1'b0;
    @(negedge CLK);
    while (!bValid) @(negedge CLK);
    checkId(testName[t], testId[t], bId);
    checkResp(testName[t], 2'b00, bResp);
    @(posedge CLK);  // bReady is always high
  endtask

  task automatic readBurst(input int t);
    int got;
    logic holdOff;
    got = 0;
    @(posedge CLK);
    arValid <= 1'b1;
    arAddr <= testAddr[t];
    arId <= testId[t];
    arLen <= testLen[t];
    @(negedge CLK);
    while (!arReady) @(negedge CLK);
    while (got <= int'(testLen[t])) begin
      @(posedge CLK);
      arValid <= 1'b0;
      holdOff = lfsr[0];
      lfsr = lfsrStep(lfsr);
      rReady <= !holdOff;
      @(negedge CLK);
      if (rValid && rReady) begin
        checkData(testName[t], testWords[t][got], rData);
        checkId(testName[t], testId[t], rId);
        checkResp(testName[t], 2'b00, rResp);
        checkLast(testName[t], got == int'(testLen[t]), rLast);
        got++;
      end
    end
    @(posedge CLK);
    rReady <= 1'b0;
  endtask

  initial begin
    RST_N = 1'b0;
    awValid = 1'b0;
    awAddr = '0;
    awId = '0;
    awLen = '0;
    wValid = 1'b0;
    wData = '0;
    wLast = 1'b0;
    bReady = 1'b1;
    arValid = 1'b0;
    arAddr = '0;
    arId = '0;
    arLen = '0;
    rReady = 1'b0;
    lfsr = 8'd4;
    loaded = 1'b0;
    loadStim();
    loaded = 1'b1;
    repeat (10) @(posedge CLK);
    RST_N <= 1'b1;
    @(posedge CLK);
    for (int t = 0; t < numTests; t++) begin
      if (testOp[t] == "W")
        writeBurst(t);
      else if (testOp[t] == "R")
        readBurst(t);
      else begin
        @(posedge CLK);
        @(negedge CLK);
        checkIrq(testName[t], testWords[t][0][0], irq);
      end
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

  initial begin
    wait (loaded);
    repeat (numTests * CYCLES_PER_TEST + 10) @(posedge CLK);
    $display("Timeout: the tests did not finish within %0d cycles",
             numTests * CYCLES_PER_TEST + 10);
    stopRun();
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+source
source/axiPkg.sv
source/portalPkg.sv
source/beatIf.sv
source/beatQueue.sv
source/burstSplitter.sv
source/portalReadPath.sv
source/portalWritePath.sv
source/echoPortal.sv
source/zynqPortalTop.sv
tests/portalTb.sv

// File: tests/portalStim.txt
# name op addr len id words (all hex); op W writes the words, R expects them
# op I expects irq equal to the first word; its addr, len and id are 0
ctrlBurst R 0008 3 01 00000001 00000000 00000005 00000001
unmapped R 0018 0 02 005A05A0
highAlias R 1008 0 20 00000001
enableDefault R 0004 0 03 00000000
pushOne W 0020 0 04 CAFE0001
queueOne R 000C 0 05 00000001
statusOne R 0000 0 06 00000001
notFullOne R 0030 0 07 00000001
irqOffPending I 0 0 0 0
drainOne R 0020 0 08 CAFE0001
pushFour W 0020 3 09 11111111 22222222 33333333 44444444
popFour R 0020 3 0A 11111111 22222222 33333333 44444444
queueEmpty R 000C 0 0B 00000000
ctrlIgnore W 0008 0 2A FFFFFFFF
tilesKept R 0008 0 2B 00000001
enableIrq W 0004 0 0C 00000001
enableRead R 0004 0 0D 00000001
irqIdle I 0 0 0 0
pushIrq W 0020 0 0E 0BADF00D
irqHigh I 0 0 0 1
popIrq R 0020 0 0F 0BADF00D
irqDrained I 0 0 0 0
disableIrq W 0004 0 10 00000000
pushQuiet W 0040 0 11 5EED0001
irqQuiet I 0 0 0 0
popQuiet R 0024 0 12 5EED0001
fillEight W 003C 7 13 DA7A0000 DA7A0001 DA7A0002 DA7A0003 DA7A0004 DA7A0005 DA7A0006 DA7A0007
queueFull R 000C 0 14 00000008
notFullFull R 0030 0 15 00000000
mixedWrap R 0028 7 16 DA7A0000 DA7A0001 00000001 00000001 00000001 00000001 DA7A0002 DA7A0003
popRest R 0020 3 17 DA7A0004 DA7A0005 DA7A0006 DA7A0007
queueDone R 000C 0 18 00000000
idMax R 0010 0 3F 00000005
